// ==== verilog.f ====
mgr_pkg.sv
wu_stream_if.sv
wu_fetch.sv
wu_fifo.sv
oob_downstream_cntl.sv
manager.sv
tb_manager.sv

// ==== Makefile ====
# Verilator build and run for the manager testbench

.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module tb_manager -f verilog.f
	./obj_dir/Vtb_manager | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_manager.sv ====
// Manager testbench

`timescale 1ns/1ns

module tb_manager import mgr_pkg::*; ();

  localparam int timeout_cyc = 2000;        // Cycles allowed per wait

  logic                  clk;
  logic                  reset;
  logic                  wu_wr_en;
  logic [wu_addr_w-1:0]  wu_wr_addr;
  logic [inst_w-1:0]     wu_wr_data;
  logic                  start;
  logic [wu_addr_w-1:0]  start_addr;
  logic                  busy;
  logic                  oob_valid;
  logic                  oob_ready;
  cntl_t                 oob_cntl;
  oob_type_t             oob_type;
  logic [oob_data_w-1:0] oob_data;

  logic [inst_w-1:0] model_mem [wu_depth];  // Mirror of the work-unit memory
  logic [19:0]       exp_q [$];             // Expected beats {cntl, type, data}
  logic [31:0]       rng;
  logic              rand_ready;            // Random back-pressure on the stack bus
  int                beat_count;            // Beats taken on the stack bus
  int                errors;
  int                checks;

  manager UUT (
    .clk        (clk),
    .reset      (reset),
    .wu_wr_en   (wu_wr_en),
    .wu_wr_addr (wu_wr_addr),
    .wu_wr_data (wu_wr_data),
    .start      (start),
    .start_addr (start_addr),
    .busy       (busy),
    .oob_valid  (oob_valid),
    .oob_ready  (oob_ready),
    .oob_cntl   (oob_cntl),
    .oob_type   (oob_type),
    .oob_data   (oob_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                 // 20 ns period
  end

  //----------------------------------------
  // Helpers
  //----------------------------------------
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Op, tag, lanes, stop cmd, simd cmd from the top bit down
  function automatic logic [31:0] mk_inst(input logic [1:0] op, input logic [3:0] tag,
                                          input logic [5:0] lanes, input logic [9:0] stop,
                                          input logic [9:0] simd);
    return {op, tag, lanes, stop, simd};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // One write, enable dropped on the next edge
  task automatic write_word(input logic [5:0] addr, input logic [31:0] data,
                            input bit update_model);
    @(posedge clk);
    wu_wr_en   <= 1'b1;
    wu_wr_addr <= addr;
    wu_wr_data <= data;
    @(posedge clk);
    wu_wr_en   <= 1'b0;
    if (update_model)
      model_mem[addr] = data;
  endtask

  // Walk the model memory from addr up to the first end word
  task automatic build_expected(input logic [5:0] addr);
    logic [5:0]  a;
    logic [31:0] w;
    bit          done;
    int          n;
    a    = addr;
    done = 1'b0;
    n    = 0;
    exp_q.delete();
    while (!done && n < wu_depth) begin
      w = model_mem[a];
      if (w[31:30] == 2'd2)
        done = 1'b1;
      else if (w[31:30] == 2'd1) begin    // Op word, nop and code 3 skipped
        exp_q.push_back({cntl_sod, oob_num_lanes, w[29:26], 6'd0, w[25:20]});
        exp_q.push_back({cntl_mod, oob_stop_cmd,  w[29:26], 2'd0, w[19:10]});
        exp_q.push_back({cntl_eod, oob_simd_cmd,  w[29:26], 2'd0, w[9:0]});
      end
      a = a + 6'd1;                         // Wraps like the DUT
      n++;
    end
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (busy !== level && n < timeout_cyc) begin
      @(negedge clk);
      n++;
    end
    if (busy !== level) begin
      $display("Timeout after %0d cycles waiting for busy to go %0b", n, level);
      errors++;
    end
  endtask

  task automatic start_unit(input logic [5:0] addr);
    build_expected(addr);
    @(posedge clk);
    start      <= 1'b1;
    start_addr <= addr;
    @(posedge clk);
    start      <= 1'b0;
    wait_busy(1'b1);
  endtask

  // Busy falling marks the end, every expected beat must be gone
  task automatic finish_unit();
    wait_busy(1'b0);
    check_val("pending beats", 32'(exp_q.size()), 32'd0);
    check_val("oob_valid", 32'(oob_valid), 32'd0);
  endtask

  //----------------------------------------
  // Stack bus side
  //----------------------------------------
  always @(posedge clk) begin
    if (rand_ready) begin
      rng = next_rand(rng);
      oob_ready <= rng[0];
    end else
      oob_ready <= 1'b1;
  end

  always @(posedge clk) begin : beat_monitor
    logic [19:0] e;
    if (!reset && oob_valid && oob_ready) begin
      beat_count++;
      if (exp_q.size() == 0) begin
        $display("Unexpected OOB beat at %0t with data %h", $time, oob_data);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_val("oob_cntl", 32'(oob_cntl), 32'(e[19:18]));
        check_val("oob_type", 32'(oob_type), 32'(e[17:16]));
        check_val("oob_data", 32'(oob_data), 32'(e[15:0]));
      end
    end
  end

  //----------------------------------------
  // Directed tests
  //----------------------------------------
  task automatic test_reset();
    $display("Test: reset");
    @(negedge clk);
    check_val("oob_valid", 32'(oob_valid), 32'd0);
    check_val("busy", 32'(busy), 32'd0);
  endtask

  task automatic test_single_op();
    int base;
    $display("Test: single operation");
    write_word(6'd0, mk_inst(op_op, 4'h5, 6'd17, 10'h2a5, 10'h3c1), 1'b1);
    write_word(6'd1, mk_inst(op_end, 4'h0, 6'd0, 10'd0, 10'd0), 1'b1);
    base = beat_count;
    start_unit(6'd0);
    finish_unit();
    check_val("beat count", 32'(beat_count - base), 32'd3);   // One packet
  endtask

  task automatic test_filter_order();
    $display("Test: filtering and order");
    write_word(6'd10, mk_inst(op_nop, 4'h1, 6'd1, 10'd1, 10'd1), 1'b1);
    write_word(6'd11, mk_inst(op_op,  4'ha, 6'd3, 10'h011, 10'h022), 1'b1);
    write_word(6'd12, mk_inst(op_nop, 4'h2, 6'd2, 10'd2, 10'd2), 1'b1);
    write_word(6'd13, mk_inst(op_op,  4'hb, 6'd63, 10'h3ff, 10'h200), 1'b1);
    write_word(6'd14, mk_inst(2'd3,   4'h3, 6'd4, 10'd4, 10'd4), 1'b1);   // Reserved code
    write_word(6'd15, mk_inst(op_op,  4'hc, 6'd0, 10'h155, 10'h0aa), 1'b1);
    write_word(6'd16, mk_inst(op_end, 4'h0, 6'd0, 10'd0, 10'd0), 1'b1);
    write_word(6'd17, mk_inst(op_op,  4'hf, 6'd9, 10'h099, 10'h099), 1'b1); // Past the end
    start_unit(6'd10);
    finish_unit();
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    logic [1:0]  op;
    int          i;
    $display("Test: back-pressure");
    for (i = 0; i < 47; i++) begin
      rng = next_rand(rng);
      r   = rng;
      op  = (r[31:30] == op_end) ? op_op : r[31:30];   // Keep the end at the tail
      write_word(6'(i), {op, r[29:0]}, 1'b1);
    end
    write_word(6'd47, mk_inst(op_end, 4'h0, 6'd0, 10'd0, 10'd0), 1'b1);
    @(negedge clk);
    rand_ready = 1'b1;
    start_unit(6'd0);
    finish_unit();
    rand_ready = 1'b0;
  endtask

  task automatic test_start_reload();
    $display("Test: start address and reload");
    write_word(6'd60, mk_inst(op_op,  4'h6, 6'd12, 10'h123, 10'h321), 1'b1);
    write_word(6'd61, mk_inst(op_nop, 4'h0, 6'd0, 10'd0, 10'd0), 1'b1);
    write_word(6'd62, mk_inst(op_op,  4'h7, 6'd24, 10'h0f0, 10'h00f), 1'b1);
    write_word(6'd63, mk_inst(op_op,  4'h8, 6'd36, 10'h2d2, 10'h1e1), 1'b1);
    write_word(6'd0,  mk_inst(op_op,  4'h9, 6'd48, 10'h3a3, 10'h0b0), 1'b1); // After wrap
    write_word(6'd1,  mk_inst(op_end, 4'h0, 6'd0, 10'd0, 10'd0), 1'b1);
    start_unit(6'd60);
    // Ignored by the DUT, model memory left alone
    write_word(6'd62, mk_inst(op_op, 4'hd, 6'd5, 10'h055, 10'h066), 1'b0);
    write_word(6'd0,  mk_inst(op_end, 4'h0, 6'd0, 10'd0, 10'd0), 1'b0);
    @(negedge clk);
    check_val("busy", 32'(busy), 32'd1);
    finish_unit();
    start_unit(6'd60);                      // Same program again
    finish_unit();
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------
  initial begin
    reset      = 1'b1;
    wu_wr_en   = 1'b0;
    wu_wr_addr = '0;
    wu_wr_data = '0;
    start      = 1'b0;
    start_addr = '0;
    oob_ready  = 1'b0;
    rand_ready = 1'b0;
    rng        = 32'd21273;
    beat_count = 0;
    errors     = 0;
    checks     = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    test_reset();
    test_single_op();
    test_filter_order();
    test_backpressure();
    test_start_reload();

    repeat (2) @(posedge clk);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== manager.sv ====
// Cortical processor manager top

`timescale 1ns/1ns

module manager import mgr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,

  // Work-unit memory load
  input  logic                  wu_wr_en,
  input  logic [wu_addr_w-1:0]  wu_wr_addr,
  input  logic [inst_w-1:0]     wu_wr_data,

  // Work-unit start
  input  logic                  start,
  input  logic [wu_addr_w-1:0]  start_addr,
  output logic                  busy,        // Falls when the work-unit is done

  // Stack bus, OOB downstream
  output logic                  oob_valid,
  input  logic                  oob_ready,
  output cntl_t                 oob_cntl,
  output oob_type_t             oob_type,
  output logic [oob_data_w-1:0] oob_data
);

  logic fetching;
  logic fifo_empty;
  logic oob_idle;
  logic start_ok;
  logic wr_ok;

  wu_stream_if fetch_q ();                  // Fetch to buffer
  wu_stream_if oob_q ();                    // Buffer to transmitter

  // Busy while any stage still holds part of the work-unit
  assign busy = fetching || !fifo_empty || !oob_idle;

  assign start_ok = start && !busy;         // Start only when quiet
  assign wr_ok    = wu_wr_en && !busy;      // Memory frozen while running

  //----------------------------------------
  // Fetch
  //----------------------------------------
  wu_fetch u_wu_fetch (
    .clk        (clk),
    .reset      (reset),
    .start      (start_ok),
    .start_addr (start_addr),
    .wu_wr_en   (wr_ok),
    .wu_wr_addr (wu_wr_addr),
    .wu_wr_data (mgr_inst_t'(wu_wr_data)),
    .fetching   (fetching),
    .fetch_q    (fetch_q)
  );

  // Instruction buffer
  wu_fifo #(
    .payload_t (mgr_inst_t),
    .depth     (fifo_depth_dflt)
  ) u_wu_fifo (
    .clk   (clk),
    .reset (reset),
    .in_q  (fetch_q),
    .out_q (oob_q),
    .empty (fifo_empty)
  );

  //----------------------------------------
  // OOB transmitter
  //----------------------------------------
  oob_downstream_cntl u_oob_downstream_cntl (
    .clk       (clk),
    .reset     (reset),
    .inst_q    (oob_q),
    .oob_valid (oob_valid),
    .oob_ready (oob_ready),
    .oob_cntl  (oob_cntl),
    .oob_type  (oob_type),
    .oob_data  (oob_data),
    .idle      (oob_idle)
  );

endmodule

// ==== oob_downstream_cntl.sv ====
// OOB downstream transmitter

`timescale 1ns/1ns

module oob_downstream_cntl import mgr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  wu_stream_if.dst              inst_q,     // Instructions from the buffer
  output logic                  oob_valid,
  input  logic                  oob_ready,
  output cntl_t                 oob_cntl,
  output oob_type_t             oob_type,
  output logic [oob_data_w-1:0] oob_data,
  output logic                  idle        // Nothing held or pending
);

  mgr_inst_t inst;                          // Instruction being sent
  logic      hold_vld;
  logic      wu_open;                       // Work-unit has more ops to come
  logic [1:0] beat;                         // 0 lanes, 1 stop, 2 simd
  logic      accept;
  logic      pkt_done;

  logic [oob_val_w-1:0] beat_val;

  // Last beat taken this edge, new item can load behind it
  assign pkt_done = hold_vld && oob_ready && (beat == oob_last_beat);

  assign inst_q.ready = !hold_vld || pkt_done;
  assign accept       = inst_q.valid && inst_q.ready;

  //----------------------------------------
  // Beat sequencing
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_vld <= 1'b0;
      beat     <= '0;
      wu_open  <= 1'b0;
    end else begin
      if (accept) begin
        hold_vld <= 1'b1;
        beat     <= '0;
        wu_open  <= !inst_q.last;           // Closed by the last op
      end else if (pkt_done) begin
        hold_vld <= 1'b0;
        beat     <= '0;
      end else if (hold_vld && oob_ready) begin
        beat <= beat + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      inst <= inst_q.payload;
  end

  // Field decode per beat
  always_comb begin
    case (beat)
      2'd0: begin
        oob_cntl = cntl_sod;
        oob_type = oob_num_lanes;
        beat_val = oob_val_w'(inst.num_lanes);
      end
      2'd1: begin
        oob_cntl = cntl_mod;
        oob_type = oob_stop_cmd;
        beat_val = oob_val_w'(inst.stop_cmd);
      end
      default: begin
        oob_cntl = cntl_eod;
        oob_type = oob_simd_cmd;
        beat_val = oob_val_w'(inst.simd_cmd);
      end
    endcase
  end

  assign oob_data  = {inst.tag, beat_val};  // Tag in the top bits
  assign oob_valid = hold_vld;

  assign idle = !hold_vld && !wu_open;

endmodule

// ==== wu_fifo.sv ====
// Instruction buffer

`timescale 1ns/1ns

module wu_fifo import mgr_pkg::*; #(
  parameter type payload_t = mgr_inst_t,
  parameter int  depth     = fifo_depth_dflt   // At least 2
) (
  input  logic     clk,
  input  logic     reset,
  wu_stream_if.dst in_q,        // From fetch
  wu_stream_if.src out_q,       // To the OOB transmitter
  output logic     empty
);

  // Payload and last share one entry
  typedef struct packed {
    logic     last;
    payload_t payload;
  } entry_t;

  typedef logic [$clog2(depth)-1:0]   ptr_t;
  typedef logic [$clog2(depth+1)-1:0] cnt_t;

  entry_t fifo_mem [depth];
  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  cnt_t   count;                // Entries held
  logic   push;
  logic   pop;

  // Pointer step with wrap for any depth
  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == ptr_t'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push = in_q.valid && in_q.ready;
  assign pop  = out_q.valid && out_q.ready;

  assign in_q.ready = (count != cnt_t'(depth));     // Not full

  // Fall-through read side, head entry shown directly
  assign out_q.valid   = (count != '0);
  assign out_q.payload = fifo_mem[rd_ptr].payload;
  assign out_q.last    = fifo_mem[rd_ptr].last;

  assign empty = (count == '0);

  //----------------------------------------
  // Storage
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr].payload <= in_q.payload;
      fifo_mem[wr_ptr].last    <= in_q.last;
    end
  end

  // Pointers and count
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                          // Both or neither, no change
      endcase
    end
  end

endmodule

// ==== wu_fetch.sv ====
// Work-unit fetch

`timescale 1ns/1ns

module wu_fetch import mgr_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,       // Begin a work-unit
  input  logic [wu_addr_w-1:0] start_addr,
  input  logic                 wu_wr_en,    // Memory load port
  input  logic [wu_addr_w-1:0] wu_wr_addr,
  input  mgr_inst_t            wu_wr_data,
  output logic                 fetching,    // Work-unit still in fetch
  wu_stream_if.src             fetch_q      // Op words toward the buffer
);

  mgr_inst_t wu_mem [wu_depth];             // Work-unit instruction store

  logic                 active;             // Walking addresses
  logic [wu_addr_w-1:0] rd_addr;
  logic                 rd_en;

  // Read stage, one word from memory
  mgr_inst_t rd_word;
  logic      rd_vld;                        // rd_word not yet consumed
  logic      word_op;
  logic      word_end;
  logic      consume;

  // Candidate op, held back until we know if it is the last one
  mgr_inst_t cand;
  logic      cand_vld;

  // Output slot driving the stream
  mgr_inst_t out_word;
  logic      out_last;
  logic      out_vld;
  logic      slot_free;
  logic      load_out;

  //----------------------------------------
  // Memory, sync write and sync read
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (wu_wr_en)
      wu_mem[wu_wr_addr] <= wu_wr_data;
    if (rd_en)
      rd_word <= wu_mem[rd_addr];           // One cycle read latency
  end

  // Word kind
  always_comb begin
    word_op  = 1'b0;
    word_end = 1'b0;
    case (rd_word.op)
      op_op:   word_op  = 1'b1;
      op_end:  word_end = 1'b1;
      op_nop:  ;                            // Dropped
      default: ;                            // Reserved code, dropped too
    endcase
  end

  assign slot_free = !out_vld || fetch_q.ready;   // Slot empties this edge

  // Nops always go, op and end need room when a candidate must move out
  assign consume  = rd_vld && (!(word_op || word_end) || !cand_vld || slot_free);
  assign load_out = consume && cand_vld && (word_op || word_end);

  // Next read only when the read stage frees up, never past the end word
  assign rd_en = active && !(consume && word_end) && (!rd_vld || consume);

  //----------------------------------------
  // Control
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      rd_addr  <= '0;
      rd_vld   <= 1'b0;
      cand_vld <= 1'b0;
      out_vld  <= 1'b0;
    end else begin
      if (start)
        active <= 1'b1;
      else if (consume && word_end)
        active <= 1'b0;                     // End word stops the walk

      if (start)
        rd_addr <= start_addr;
      else if (rd_en)
        rd_addr <= rd_addr + 1'b1;          // Wraps at wu_depth

      if (start)
        rd_vld <= 1'b0;
      else if (rd_en)
        rd_vld <= 1'b1;
      else if (consume)
        rd_vld <= 1'b0;

      if (start)
        cand_vld <= 1'b0;
      else if (consume && word_op)
        cand_vld <= 1'b1;
      else if (consume && word_end)
        cand_vld <= 1'b0;

      if (load_out)
        out_vld <= 1'b1;
      else if (fetch_q.ready)
        out_vld <= 1'b0;
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (consume && word_op)
      cand <= rd_word;
    if (load_out) begin
      out_word <= cand;
      out_last <= word_end;                 // Followed by end, so last op
    end
  end

  assign fetch_q.valid   = out_vld;
  assign fetch_q.payload = out_word;
  assign fetch_q.last    = out_last;

  assign fetching = active || out_vld;      // Covers the final push

endmodule

// ==== wu_stream_if.sv ====
// Instruction stream interface

`timescale 1ns/1ns

interface wu_stream_if import mgr_pkg::*; #(
  parameter type payload_t = mgr_inst_t         // Item carried per transfer
);

  logic     valid;     // Item on the bus
  logic     ready;     // Sink can take it
  payload_t payload;
  logic     last;      // Last operation of the work-unit

  // Transfer on any edge with valid and ready high
  // Valid, payload and last hold steady until then

  // Producer side
  modport src (
    output valid,
    output payload,
    output last,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  payload,
    input  last,
    output ready
  );

endinterface

// ==== mgr_pkg.sv ====
// Manager shared definitions

package mgr_pkg;

  //----------------------------------------
  // Work-unit memory geometry
  //----------------------------------------
  localparam int wu_addr_w = 6;                 // Word address width
  localparam int wu_depth  = 1 << wu_addr_w;    // 64 instruction words
  localparam int inst_w    = 32;                // One instruction per word

  // Instruction field widths
  localparam int op_w    = 2;
  localparam int tag_w   = 4;
  localparam int lanes_w = 6;                   // Lane count
  localparam int cmd_w   = 10;                  // Streaming op and SIMD commands

  // Instruction kinds, code 3 is reserved and skipped like a nop
  localparam logic [op_w-1:0] op_nop = 2'd0;
  localparam logic [op_w-1:0] op_op  = 2'd1;
  localparam logic [op_w-1:0] op_end = 2'd2;    // Closes the work-unit

  // Packed instruction word, op in the top bits
  typedef struct packed {
    logic [op_w-1:0]    op;
    logic [tag_w-1:0]   tag;        // Travels with every OOB beat
    logic [lanes_w-1:0] num_lanes;
    logic [cmd_w-1:0]   stop_cmd;   // Streaming operation command
    logic [cmd_w-1:0]   simd_cmd;
  } mgr_inst_t;

  //----------------------------------------
  // Stack bus delimiters
  //----------------------------------------
  typedef logic [1:0] cntl_t;

  localparam cntl_t cntl_sod = 2'd1;            // Start of data
  localparam cntl_t cntl_mod = 2'd2;            // Middle of data
  localparam cntl_t cntl_eod = 2'd3;            // End of data

  // OOB beat types, one per configuration field
  typedef logic [1:0] oob_type_t;

  localparam oob_type_t oob_num_lanes = 2'd0;
  localparam oob_type_t oob_stop_cmd  = 2'd1;
  localparam oob_type_t oob_simd_cmd  = 2'd2;

  // OOB data is tag over a zero-extended field value
  localparam int oob_data_w = 16;
  localparam int oob_val_w  = oob_data_w - tag_w;

  // Three beats per packet, counter runs 0 to 2
  localparam logic [1:0] oob_last_beat = 2'd2;

  //----------------------------------------
  // Buffering
  //----------------------------------------
  localparam int fifo_depth_dflt = 4;           // Instructions between fetch and OOB

endpackage
